/* logic/sys_params.svh */
// ~~~~~~~~~~~~~~~~~~~~
// Shared defines for the system pipe
// Data and APB widths, CSR addresses,
// mcause codes, timer register offsets
// ~~~~~~~~~~~~~~~~~~~~
`ifndef SYS_PARAMS_SVH
`define SYS_PARAMS_SVH

`define SYS_XLEN       32
`define SYS_APB_AW     4

`define CSR_MSTATUS    12'h300
`define CSR_MIE        12'h304
`define CSR_MTVEC      12'h305
`define CSR_MSCRATCH   12'h340
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342
`define CSR_MIP        12'h344

`define CAUSE_ILLEGAL  32'h0000_0002
`define CAUSE_ECALL    32'h0000_000b
`define CAUSE_MTI      32'h8000_0007
`define CAUSE_MEI      32'h8000_000b

// Offsets are SYS_APB_AW bits wide
`define TMR_MTIME      4'h0
`define TMR_MTIMECMP   4'h4

`endif

/* logic/sys_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// System pipe types
// Instruction word union (CSR and privileged views),
// CSR operation enum, trap FSM state enum
// ~~~~~~~~~~~~~~~~~~~~
package sys_pkg;

  typedef union packed {
    struct packed {
      logic [11:0] csr;
      logic [4:0]  rs1;     // Also zimm for the immediate forms
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } csr_view;
    struct packed {
      logic [6:0]  funct7;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } priv_view;
  } sys_instr_u;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_RW,
    OP_RS,
    OP_RC,
    OP_ECALL,
    OP_MRET
  } csr_op_e;

  typedef enum logic [1:0] {
    IDLE,
    TAKE_IRQ,
    REDIRECT
  } trap_state_e;

endpackage

/* logic/sys_mtimer.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Machine timer
// Free-running mtime, mtimecmp compare,
// APB slave without wait states
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_mtimer
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`SYS_APB_AW-1:0] paddr_i,
  input  logic [`SYS_XLEN-1:0]   pwdata_i,
  output logic [`SYS_XLEN-1:0]   prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  output logic                   timer_irq_o
);

  logic [`SYS_XLEN-1:0] mtime_q;
  logic [`SYS_XLEN-1:0] mtimecmp_q;
  logic                 access;
  logic                 hit_time;
  logic                 hit_cmp;

  assign access      = psel_i & penable_i;
  assign hit_time    = (paddr_i == `TMR_MTIME);
  assign hit_cmp     = (paddr_i == `TMR_MTIMECMP);
  assign pready_o    = psel_i;  // No wait states
  assign pslverr_o   = access & ~(hit_time | hit_cmp);
  assign prdata_o    = hit_time ? mtime_q : (hit_cmp ? mtimecmp_q : '0);
  assign timer_irq_o = (mtime_q >= mtimecmp_q);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // Timer quiet until programmed
    end
    else
    begin
      if (access && pwrite_i && hit_time)
        mtime_q <= pwdata_i;
      else
        mtime_q <= mtime_q + 1'b1;
      if (access && pwrite_i && hit_cmp)
        mtimecmp_q <= pwdata_i;
    end
  end

endmodule

/* logic/sys_issue_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Issue stage
// Instruction decode, two-stage pipeline registers,
// next-pc register for interrupt entry
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_issue_stage
  import sys_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 valid_i,
  input  logic                 ready_i,
  input  logic [31:0]          instr_i,
  input  logic [`SYS_XLEN-1:0] pc_i,
  input  logic [`SYS_XLEN-1:0] rs1_i,
  output logic                 s2_v_o,
  output csr_op_e              s2_op_o,
  output logic [11:0]          s2_addr_o,
  output logic [`SYS_XLEN-1:0] s2_operand_o,
  output logic [4:0]           s2_rd_o,
  output logic [`SYS_XLEN-1:0] s2_pc_o,
  output logic                 busy_o,
  output logic [`SYS_XLEN-1:0] npc_o
);

  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
  localparam logic [6:0] F7_MRET    = 7'b0011000;
  localparam logic [4:0] RS2_MRET   = 5'b00010;

  logic                 accept;
  logic                 s1_v_q;
  sys_instr_u           s1_instr_q;
  logic [`SYS_XLEN-1:0] s1_pc_q;
  logic [`SYS_XLEN-1:0] s1_rs1_q;
  csr_op_e              s1_op;
  logic [`SYS_XLEN-1:0] s1_operand;

  assign accept = valid_i & ready_i;
  assign busy_o = s1_v_q | s2_v_o;

  always_comb
  begin
    s1_op = OP_NONE;
    if (s1_instr_q.csr_view.opcode == OPC_SYSTEM)
    begin
      case (s1_instr_q.csr_view.funct3)
        3'b001, 3'b101: s1_op = OP_RW;
        3'b010, 3'b110: s1_op = OP_RS;
        3'b011, 3'b111: s1_op = OP_RC;
        3'b000:
        begin
          if (s1_instr_q.priv_view.funct7 == 7'd0 && s1_instr_q.priv_view.rs2 == 5'd0)
            s1_op = OP_ECALL;
          else if (s1_instr_q.priv_view.funct7 == F7_MRET &&
                   s1_instr_q.priv_view.rs2 == RS2_MRET)
            s1_op = OP_MRET;
        end
        default: s1_op = OP_NONE;
      endcase
    end
  end

  // funct3[2] marks the zimm forms
  assign s1_operand = s1_instr_q.csr_view.funct3[2]
                    ? {{(`SYS_XLEN-5){1'b0}}, s1_instr_q.csr_view.rs1}
                    : s1_rs1_q;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      s1_v_q <= 1'b0;
      s2_v_o <= 1'b0;
      npc_o  <= '0;
    end
    else
    begin
      s1_v_q <= accept;
      s2_v_o <= s1_v_q;
      if (s2_v_o)
        npc_o <= s2_pc_o + `SYS_XLEN'd4;  // Resume point after the retiring op
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      s1_instr_q <= instr_i;
      s1_pc_q    <= pc_i;
      s1_rs1_q   <= rs1_i;
    end
    if (s1_v_q)
    begin
      s2_op_o      <= s1_op;
      s2_addr_o    <= s1_instr_q.csr_view.csr;
      s2_operand_o <= s1_operand;
      s2_rd_o      <= s1_instr_q.csr_view.rd;
      s2_pc_o      <= s1_pc_q;
    end
  end

endmodule

/* logic/sys_csr_file.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Machine CSR file
// Read-modify-write for CSRRW/RS/RC, illegal address check,
// trap entry and MRET update of mstatus, interrupt pending logic
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_csr_file
  import sys_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 s2_v_i,
  input  csr_op_e              s2_op_i,
  input  logic [11:0]          s2_addr_i,
  input  logic [`SYS_XLEN-1:0] s2_operand_i,
  input  logic                 trap_we_i,
  input  logic [`SYS_XLEN-1:0] trap_cause_i,
  input  logic [`SYS_XLEN-1:0] trap_epc_i,
  input  logic                 mret_i,
  input  logic                 timer_irq_i,
  input  logic                 ext_irq_i,
  output logic [`SYS_XLEN-1:0] rdata_o,
  output logic                 illegal_o,
  output logic                 irq_pending_o,
  output logic [`SYS_XLEN-1:0] irq_cause_o,
  output logic [`SYS_XLEN-1:0] mtvec_o,
  output logic [`SYS_XLEN-1:0] mepc_o
);

  logic                 mie_q, mpie_q;   // mstatus bits 3 and 7
  logic                 mtie_q, meie_q;  // mie bits 7 and 11
  logic [`SYS_XLEN-1:0] mtvec_q, mscratch_q, mepc_q, mcause_q;
  logic                 addr_ok;
  logic                 csr_op;
  logic                 csr_we;
  logic [`SYS_XLEN-1:0] wdata;
  logic                 mei_en, mti_en;

  always_comb
  begin
    addr_ok = 1'b1;
    rdata_o = '0;
    case (s2_addr_i)
      `CSR_MSTATUS:
      begin
        rdata_o[3] = mie_q;
        rdata_o[7] = mpie_q;
      end
      `CSR_MIE:
      begin
        rdata_o[7]  = mtie_q;
        rdata_o[11] = meie_q;
      end
      `CSR_MIP:
      begin
        rdata_o[7]  = timer_irq_i;
        rdata_o[11] = ext_irq_i;
      end
      `CSR_MTVEC:    rdata_o = mtvec_q;
      `CSR_MSCRATCH: rdata_o = mscratch_q;
      `CSR_MEPC:     rdata_o = mepc_q;
      `CSR_MCAUSE:   rdata_o = mcause_q;
      default:       addr_ok = 1'b0;
    endcase
  end

  always_comb
  begin
    case (s2_op_i)
      OP_RS:   wdata = rdata_o | s2_operand_i;
      OP_RC:   wdata = rdata_o & ~s2_operand_i;
      default: wdata = s2_operand_i;
    endcase
  end

  assign csr_op    = s2_v_i & (s2_op_i inside {OP_RW, OP_RS, OP_RC});
  assign illegal_o = csr_op & ~addr_ok;
  assign csr_we    = csr_op & addr_ok;

  assign mei_en        = ext_irq_i & meie_q;
  assign mti_en        = timer_irq_i & mtie_q;
  assign irq_pending_o = mie_q & (mei_en | mti_en);
  assign irq_cause_o   = mei_en ? `CAUSE_MEI : `CAUSE_MTI;  // External first
  assign mtvec_o       = mtvec_q;
  assign mepc_o        = mepc_q;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mie_q      <= 1'b0;
      mpie_q     <= 1'b0;
      mtie_q     <= 1'b0;
      meie_q     <= 1'b0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end
    else
    begin
      if (csr_we)
      begin
        case (s2_addr_i)
          `CSR_MSTATUS:
          begin
            mie_q  <= wdata[3];
            mpie_q <= wdata[7];
          end
          `CSR_MIE:
          begin
            mtie_q <= wdata[7];
            meie_q <= wdata[11];
          end
          `CSR_MTVEC:    mtvec_q    <= wdata;
          `CSR_MSCRATCH: mscratch_q <= wdata;
          `CSR_MEPC:     mepc_q     <= wdata;
          `CSR_MCAUSE:   mcause_q   <= wdata;
          default:       ;  // mip ignores writes
        endcase
      end
      if (trap_we_i)
      begin
        mepc_q   <= trap_epc_i;
        mcause_q <= trap_cause_i;
        mpie_q   <= mie_q;
        mie_q    <= 1'b0;
      end
      else if (mret_i)
        mie_q <= mpie_q;
    end
  end

endmodule

/* logic/sys_trap_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Trap state machine
// Exception and MRET redirects from stage 2,
// interrupt entry when the pipe is empty
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_trap_fsm
  import sys_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 s2_v_i,
  input  csr_op_e              s2_op_i,
  input  logic [`SYS_XLEN-1:0] s2_pc_i,
  input  logic                 illegal_i,
  input  logic                 busy_i,
  input  logic                 irq_pending_i,
  input  logic [`SYS_XLEN-1:0] irq_cause_i,
  input  logic [`SYS_XLEN-1:0] npc_i,
  input  logic [`SYS_XLEN-1:0] mtvec_i,
  input  logic [`SYS_XLEN-1:0] mepc_i,
  output logic                 ready_o,
  output logic                 exc_v_o,
  output logic                 trap_we_o,
  output logic [`SYS_XLEN-1:0] trap_cause_o,
  output logic [`SYS_XLEN-1:0] trap_epc_o,
  output logic                 mret_o,
  output logic                 redirect_v_o,
  output logic [`SYS_XLEN-1:0] redirect_pc_o
);

  trap_state_e          state_q, state_d;
  logic [`SYS_XLEN-1:0] irq_cause_q;
  logic                 idle;
  logic                 irq_take;
  logic                 exc_take;

  assign idle     = (state_q == IDLE);
  assign irq_take = idle & irq_pending_i & ~busy_i;
  assign exc_v_o  = s2_v_i & ((s2_op_i == OP_ECALL) | illegal_i);
  assign exc_take = idle & exc_v_o;
  assign mret_o   = idle & s2_v_i & (s2_op_i == OP_MRET);
  assign ready_o  = idle & ~irq_take;  // Interrupt wins over a new dispatch

  always_comb
  begin
    case (state_q)
      IDLE:     state_d = irq_take ? TAKE_IRQ : IDLE;
      TAKE_IRQ: state_d = REDIRECT;
      default:  state_d = IDLE;
    endcase
  end

  always_comb
  begin
    trap_we_o     = exc_take;
    trap_cause_o  = illegal_i ? `CAUSE_ILLEGAL : `CAUSE_ECALL;
    trap_epc_o    = s2_pc_i;
    redirect_v_o  = exc_take | mret_o | (state_q == REDIRECT);
    redirect_pc_o = mret_o ? mepc_i : mtvec_i;
    if (state_q == TAKE_IRQ)
    begin
      trap_we_o    = 1'b1;
      trap_cause_o = irq_cause_q;
      trap_epc_o   = npc_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // Cause frozen at entry since the source may drop meanwhile
  always_ff @(posedge clk_i)
  begin
    if (irq_take)
      irq_cause_q <= irq_cause_i;
  end

endmodule

/* logic/sys_pipe_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// System pipe top level
// Issue stage, CSR file, trap FSM, machine timer
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_pipe_top
  import sys_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   valid_i,
  input  logic [31:0]            instr_i,
  input  logic [`SYS_XLEN-1:0]   pc_i,
  input  logic [`SYS_XLEN-1:0]   rs1_i,
  output logic                   ready_o,
  output logic                   v_o,
  output logic [`SYS_XLEN-1:0]   data_o,
  output logic [4:0]             rd_o,
  output logic                   exc_v_o,
  output logic                   redirect_v_o,
  output logic [`SYS_XLEN-1:0]   redirect_pc_o,
  input  logic                   ext_irq_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`SYS_APB_AW-1:0] paddr_i,
  input  logic [`SYS_XLEN-1:0]   pwdata_i,
  output logic [`SYS_XLEN-1:0]   prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  csr_op_e              s2_op;
  logic [11:0]          s2_addr;
  logic [`SYS_XLEN-1:0] s2_operand;
  logic [`SYS_XLEN-1:0] s2_pc;
  logic                 busy;
  logic [`SYS_XLEN-1:0] npc;
  logic                 illegal;
  logic                 irq_pending;
  logic [`SYS_XLEN-1:0] irq_cause;
  logic [`SYS_XLEN-1:0] mtvec;
  logic [`SYS_XLEN-1:0] mepc;
  logic                 trap_we;
  logic [`SYS_XLEN-1:0] trap_cause;
  logic [`SYS_XLEN-1:0] trap_epc;
  logic                 mret;
  logic                 timer_irq;

  sys_issue_stage sys_issue_stage_inst (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .valid_i(valid_i), .ready_i(ready_o), .instr_i(instr_i), .pc_i(pc_i), .rs1_i(rs1_i),
    .s2_v_o(v_o), .s2_op_o(s2_op), .s2_addr_o(s2_addr), .s2_operand_o(s2_operand),
    .s2_rd_o(rd_o), .s2_pc_o(s2_pc), .busy_o(busy), .npc_o(npc)
  );

  sys_csr_file sys_csr_file_inst (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .s2_v_i(v_o), .s2_op_i(s2_op), .s2_addr_i(s2_addr), .s2_operand_i(s2_operand),
    .trap_we_i(trap_we), .trap_cause_i(trap_cause), .trap_epc_i(trap_epc), .mret_i(mret),
    .timer_irq_i(timer_irq), .ext_irq_i(ext_irq_i),
    .rdata_o(data_o), .illegal_o(illegal), .irq_pending_o(irq_pending),
    .irq_cause_o(irq_cause), .mtvec_o(mtvec), .mepc_o(mepc)
  );

  sys_trap_fsm sys_trap_fsm_inst (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .s2_v_i(v_o), .s2_op_i(s2_op), .s2_pc_i(s2_pc), .illegal_i(illegal), .busy_i(busy),
    .irq_pending_i(irq_pending), .irq_cause_i(irq_cause),
    .npc_i(npc), .mtvec_i(mtvec), .mepc_i(mepc),
    .ready_o(ready_o), .exc_v_o(exc_v_o),
    .trap_we_o(trap_we), .trap_cause_o(trap_cause), .trap_epc_o(trap_epc), .mret_o(mret),
    .redirect_v_o(redirect_v_o), .redirect_pc_o(redirect_pc_o)
  );

  sys_mtimer sys_mtimer_inst (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i),
    .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
    .timer_irq_o(timer_irq)
  );

endmodule

/* tb/sys_pipe_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Bound checks for the system pipe
// Result timing, redirect pulse width,
// ready low during interrupt entry
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sys_pipe_properties
  import sys_pkg::*;
(
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        valid_i,
  input logic        ready_o,
  input logic        v_o,
  input logic        redirect_v_o,
  input trap_state_e state_i
);

  // Result two edges after acceptance and never otherwise
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i && ready_o |-> ##2 v_o)
    else $error("v_o missing two cycles after acceptance");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    v_o |-> $past(valid_i && ready_o, 2))
    else $error("v_o without acceptance two cycles earlier");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    redirect_v_o |=> !redirect_v_o)
    else $error("redirect_v_o longer than one cycle");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    state_i == TAKE_IRQ |-> !ready_o)
    else $error("ready_o high during interrupt entry");

endmodule

bind sys_pipe_top sys_pipe_properties sys_pipe_properties_inst (
  .clk_i(clk_i), .rst_n_i(rst_n_i), .valid_i(valid_i), .ready_o(ready_o),
  .v_o(v_o), .redirect_v_o(redirect_v_o), .state_i(sys_trap_fsm_inst.state_q)
);

/* tb/sys_pipe_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the system pipe
// Vector file driven dispatch, APB and interrupt tests
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sys_pipe_tb;

  logic        clk_i;
  logic        rst_n_i;
  logic        valid_i;
  logic [31:0] instr_i, pc_i, rs1_i;
  logic        ready_o, v_o, exc_v_o, redirect_v_o;
  logic [31:0] data_o, redirect_pc_o;
  logic [4:0]  rd_o;
  logic        ext_irq_i;
  logic        psel_i, penable_i, pwrite_i;
  logic [3:0]  paddr_i;
  logic [31:0] pwdata_i, prdata_o;
  logic        pready_o, pslverr_o;

  int errors;
  int tests;
  bit timed_out;

  sys_pipe_top sys_pipe_top_inst (.*);

  always #50 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic idle_gap;
    int n;
    n = $urandom % 3;
    repeat (n) @(negedge clk_i);
  endtask

  // Returns on the falling edge after the accepting edge
  task automatic dispatch(input logic [31:0] instr, input logic [31:0] pc,
                          input logic [31:0] rs1);
    int t;
    valid_i = 1'b1;
    instr_i = instr;
    pc_i    = pc;
    rs1_i   = rs1;
    t = 0;
    while (!ready_o && t < 50)
    begin
      @(negedge clk_i);
      t++;
    end
    if (!ready_o)
    begin
      $display("Timeout: ready_o never rose for dispatch at pc 0x%08h", pc);
      timed_out = 1'b1;
      errors++;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  task automatic single_instr(input logic [31:0] instr, input logic [31:0] pc,
                              input logic [31:0] rs1, input logic [31:0] exp_data,
                              input logic exp_exc, input logic exp_redir,
                              input logic [31:0] exp_pc);
    idle_gap();
    dispatch(instr, pc, rs1);
    check_value("v_o early", v_o, 1'b0);
    @(negedge clk_i);
    check_value("v_o", v_o, 1'b1);
    check_value("rd_o", rd_o, instr[11:7]);
    check_value("exc_v_o", exc_v_o, exp_exc);
    check_value("redirect_v_o", redirect_v_o, exp_redir);
    if (!exp_redir || exp_exc)
      check_value("data_o", data_o, exp_data);
    if (exp_redir)
      check_value("redirect_pc_o", redirect_pc_o, exp_pc);
  endtask

  task automatic back_to_back(input logic [31:0] instr, input logic [31:0] pc,
                              input logic [31:0] rs1, input logic [31:0] exp1,
                              input logic [31:0] exp2);
    idle_gap();
    dispatch(instr, pc, rs1);
    valid_i = 1'b1;  // Second one right behind
    pc_i    = pc + 32'd4;
    check_value("ready_o", ready_o, 1'b1);
    @(posedge clk_i);
    @(negedge clk_i);
    valid_i = 1'b0;
    check_value("v_o", v_o, 1'b1);
    check_value("data_o", data_o, exp1);
    @(negedge clk_i);
    check_value("v_o", v_o, 1'b1);
    check_value("data_o", data_o, exp2);
  endtask

  task automatic apb_access(input logic wr, input logic [3:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp_rdata,
                            input logic exp_err);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;
    #1;
    check_value("pready_o", pready_o, 1'b1);
    check_value("pslverr_o", pslverr_o, exp_err);
    if (!wr)
      check_value("prdata_o", prdata_o, exp_rdata);
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic irq_entry(input logic ext, input logic [31:0] exp_pc);
    int t;
    logic prev_ready;
    ext_irq_i = ext;
    #1;
    prev_ready = 1'b1;
    t = 0;
    while (!redirect_v_o && t < 20)
    begin
      prev_ready = ready_o;
      @(negedge clk_i);
      t++;
    end
    if (!redirect_v_o)
    begin
      $display("Timeout: no redirect for the pending interrupt");
      timed_out = 1'b1;
      errors++;
    end
    else
    begin
      check_value("redirect_pc_o", redirect_pc_o, exp_pc);
      check_value("ready_o in REDIRECT", ready_o, 1'b0);
      check_value("ready_o in TAKE_IRQ", prev_ready, 1'b0);
    end
    ext_irq_i = 1'b0;
    @(negedge clk_i);
  endtask

  initial
  begin
    int fd;
    int n;
    int err_before;
    string line;
    string kind;
    logic [31:0] a, b, c, d, e;
    void'($urandom(18843));
    errors = 0;
    tests = 0;
    timed_out = 1'b0;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    valid_i = 1'b0;
    instr_i = '0;
    pc_i = '0;
    rs1_i = '0;
    ext_irq_i = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    check_value("ready_o after reset", ready_o, 1'b1);
    fd = $fopen("tb/sys_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the vector file tb/sys_vectors.txt");
      errors++;
    end
    while (fd != 0 && !$feof(fd) && !timed_out)
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#")
        continue;
      n = $sscanf(line, "%s %h %h %h %h %h", kind, a, b, c, d, e);
      if (n != 6)
        continue;
      err_before = errors;
      case (kind)
        "CSR":  single_instr(a, b, c, d, 1'b0, 1'b0, 32'd0);
        "EXC":  single_instr(a, b, c, e, 1'b1, 1'b1, d);
        "MRET": single_instr(a, b, c, 32'd0, 1'b0, 1'b1, d);
        "PAIR": back_to_back(a, b, c, d, e);
        "APBW": apb_access(1'b1, a[3:0], b, 32'd0, c[0]);
        "APBR": apb_access(1'b0, a[3:0], 32'd0, b, c[0]);
        "IRQ":  irq_entry(a[0], b);
        default:
        begin
          $display("Unknown vector kind %s", kind);
          errors++;
        end
      endcase
      tests++;
      $display("test %0d %s: %s", tests, kind, (errors == err_before) ? "ok" : "mismatch");
    end
    if (fd != 0)
      $fclose(fd);
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0 && tests > 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* sim.f */
+incdir+logic
logic/sys_pkg.sv
logic/sys_mtimer.sv
logic/sys_issue_stage.sv
logic/sys_csr_file.sv
logic/sys_trap_fsm.sv
logic/sys_pipe_top.sv
tb/sys_pipe_properties.sv
tb/sys_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the system pipe testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module sys_pipe_tb -o sys_pipe_sim > build.log 2>&1 &&
./obj_dir/sys_pipe_sim > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
exit 0

/* tb/sys_vectors.txt */
# kind f1 f2 f3 f4 f5 (hex); CSR/EXC/MRET: instr pc rs1 exp_data_or_redirect exp_data
# PAIR: instr pc rs1 exp1 exp2; APBW: addr data err; APBR: addr exp_data err; IRQ: ext exp_pc
CSR  340092F3 00000100 12345678 00000000 0
CSR  34012373 00000104 0000F000 12345678 0
CSR  3401B3F3 00000108 00000678 1234F678 0
CSR  30585473 0000010C FFFFFFFF 00000000 0
CSR  3051E4F3 00000110 FFFFFFFF 00000010 0
CSR  3051F573 00000114 FFFFFFFF 00000013 0
CSR  305090F3 00000118 00000200 00000010 0
PAIR 340092F3 00000120 CAFEBABE 1234F000 CAFEBABE
EXC  7C0092F3 00001000 0000DEAD 00000200 00000000
CSR  342020F3 00000130 00000000 00000002 0
CSR  341020F3 00000134 00000000 00001000 0
CSR  340020F3 00000138 00000000 CAFEBABE 0
CSR  305020F3 0000013C 00000000 00000200 0
EXC  00000073 00002000 00000000 00000200 00000000
CSR  342020F3 00000140 00000000 0000000B 0
CSR  3000A0F3 00000144 00000080 00000000 0
MRET 30200073 00003000 00000000 00002000 0
CSR  300020F3 00000148 00000000 00000088 0
CSR  300470F3 0000014C 00000000 00000088 0
APBW 4 FFFFFF00 0 0 0
APBR 4 FFFFFF00 0 0 0
APBW 8 00000000 1 0 0
APBR C 00000000 1 0 0
APBW 4 00000000 0 0 0
CSR  3040A0F3 00000150 00000080 00000000 0
CSR  300460F3 00004000 00000000 00000080 0
IRQ  0 00000200 0 0 0
CSR  342020F3 00000160 00000000 80000007 0
CSR  341020F3 00000164 00000000 00004004 0
CSR  3040A0F3 00000168 00000800 00000080 0
CSR  300460F3 00005000 00000000 00000080 0
IRQ  1 00000200 0 0 0
CSR  342020F3 00000170 00000000 8000000B 0
CSR  341020F3 00000174 00000000 00005004 0
